// File: hdl/mmio_config.svh
// mmio peripheral subsystem parameters
// shared by the package, the RTL blocks and the testbench

`ifndef MMIO_CONFIG_SVH
`define MMIO_CONFIG_SVH

// width of the cpu byte address
`define MMIO_ADDR_WIDTH 24

// default cpu_ram depth in 32-bit words
`define MMIO_RAM_WORDS 256

// lowest bit of the 4-bit region field, address bits 23:20
`define MMIO_REGION_LSB 20

// status register after reset, red led on
`define MMIO_STATUS_RESET 2'b01

`endif

// File: hdl/mmio_pkg.sv
// mmio peripheral types
// region codes, decoder states and the request and select records

`default_nettype none

`include "mmio_config.svh"

package mmio_pkg;

    // region codes taken from address bits 23:20
    typedef enum logic [3:0] {
        region_ram    = 4'd0,
        region_status = 4'd1,
        region_dsp    = 4'd2,
        region_pad    = 4'd3,
        region_none   = 4'hf
    } region_e;

    // decoder handshake state
    typedef enum logic {
        dec_idle   = 1'b0,
        dec_issued = 1'b1
    } dec_state_e;

    // cpu request as held by the cpu until ready
    typedef struct packed {
        logic [`MMIO_ADDR_WIDTH-1:0] addr;
        logic [3:0]                  wstrb;
        logic [31:0]                 wdata;
    } bus_req_t;

    // registered select, one strobe per request
    typedef struct packed {
        logic                          strobe;
        logic                          write;
        region_e                       region;
        // word address, byte address bits 23:2
        logic [`MMIO_ADDR_WIDTH-3:0]   word_addr;
        logic [3:0]                    wstrb;
        logic [31:0]                   wdata;
    } mmio_sel_t;

endpackage

`default_nettype wire

// File: hdl/address_decoder.sv
// address decoder
// registers each new cpu request and issues a single-cycle
// select strobe for the addressed region

`default_nettype none

`include "mmio_config.svh"

module address_decoder (
    input  logic                vdp_clk,
    input  logic                vdp_reset,
    input  logic                mem_valid,
    input  mmio_pkg::bus_req_t  mem_req,
    output mmio_pkg::mmio_sel_t sel
);

    mmio_pkg::dec_state_e state;
    mmio_pkg::region_e    region_dec;
    logic [3:0]           region_field;
    logic                 accept;

    assign region_field = mem_req.addr[`MMIO_REGION_LSB +: 4];

    // only the first cycle of a valid request is accepted
    assign accept = (state == mmio_pkg::dec_idle) && mem_valid;

    // unmapped fields fold into region_none
    always_comb begin
        case (region_field)
            4'd0:    region_dec = mmio_pkg::region_ram;
            4'd1:    region_dec = mmio_pkg::region_status;
            4'd2:    region_dec = mmio_pkg::region_dsp;
            4'd3:    region_dec = mmio_pkg::region_pad;
            default: region_dec = mmio_pkg::region_none;
        endcase
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            state      <= mmio_pkg::dec_idle;
            sel.strobe <= 1'b0;
        end else begin
            sel.strobe <= 1'b0;

            case (state)
                mmio_pkg::dec_idle: begin
                    if (mem_valid) begin
                        sel.strobe <= 1'b1;
                        state      <= mmio_pkg::dec_issued;
                    end
                end
                mmio_pkg::dec_issued: begin
                    // wait for the cpu to drop valid after ready
                    if (!mem_valid) begin
                        state <= mmio_pkg::dec_idle;
                    end
                end
                default: state <= mmio_pkg::dec_idle;
            endcase

            // request payload
            if (accept) begin
                sel.write     <= |mem_req.wstrb;
                sel.region    <= region_dec;
                sel.word_addr <= mem_req.addr[`MMIO_ADDR_WIDTH-1:2];
                sel.wstrb     <= mem_req.wstrb;
                sel.wdata     <= mem_req.wdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/cpu_ram.sv
// cpu work ram
// 32-bit words with per-byte write strobes and a registered read

`default_nettype none

`include "mmio_config.svh"

module cpu_ram #(
    parameter int depth = `MMIO_RAM_WORDS
) (
    input  logic                vdp_clk,
    input  mmio_pkg::mmio_sel_t sel,
    output logic [31:0]         ram_rdata
);

    localparam int aw = $clog2(depth);

    logic [31:0]   mem [depth];
    logic [aw-1:0] idx;
    logic          ram_en;
    logic          ram_we;

    // word address wraps at the ram depth
    assign idx = aw'(sel.word_addr % (`MMIO_ADDR_WIDTH-2)'(depth));

    assign ram_en = sel.strobe && (sel.region == mmio_pkg::region_ram);
    assign ram_we = ram_en && sel.write;

    // byte lanes
    always_ff @(posedge vdp_clk) begin
        if (ram_we) begin
            for (int b = 0; b < 4; b++) begin
                if (sel.wstrb[b]) begin
                    mem[idx][b*8 +: 8] <= sel.wdata[b*8 +: 8];
                end
            end
        end
    end

    // read on any ram strobe, old data on a write cycle
    always_ff @(posedge vdp_clk) begin
        if (ram_en) begin
            ram_rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

// File: hdl/dsp_mult.sv
// mmio multiplier
// two 16-bit operand registers and a registered signed 32-bit product,
// product follows an operand write by one cycle

`default_nettype none

module dsp_mult (
    input  logic                vdp_clk,
    input  mmio_pkg::mmio_sel_t sel,
    output logic [31:0]         dsp_result
);

    logic [15:0] mult_a;
    logic [15:0] mult_b;
    logic        dsp_we;

    assign dsp_we = sel.strobe && sel.write && (sel.region == mmio_pkg::region_dsp);

    // flat enables so the operands map onto the dsp input registers
    always_ff @(posedge vdp_clk) begin
        if (dsp_we && !sel.word_addr[0]) begin
            mult_a <= sel.wdata[15:0];
        end

        if (dsp_we && sel.word_addr[0]) begin
            mult_b <= sel.wdata[15:0];
        end

        // signed only
        dsp_result <= $signed(mult_a) * $signed(mult_b);
    end

endmodule

`default_nettype wire

// File: hdl/io_ports.sv
// io ports
// status register driving the two leds, and a gamepad port that
// latches the board buttons into a 16-bit shift register

`default_nettype none

`include "mmio_config.svh"

module io_ports (
    input  logic                vdp_clk,
    input  logic                vdp_reset,
    input  mmio_pkg::mmio_sel_t sel,
    input  logic                btn1,
    input  logic                btn2,
    input  logic                btn3,
    output logic [1:0]          status,
    output logic                pad_bit,
    output logic                led_r,
    output logic                led_b
);

    logic        status_we;
    logic        pad_we;
    logic [1:0]  pad_ctrl;
    logic        pad_latch;
    logic        pad_clk;
    logic        pad_clk_r;
    logic [15:0] pad_state;

    assign status_we = sel.strobe && sel.write && (sel.region == mmio_pkg::region_status);
    assign pad_we    = sel.strobe && sel.write && (sel.region == mmio_pkg::region_pad);

    assign led_r = status[0];
    assign led_b = status[1];

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= `MMIO_STATUS_RESET;
        end else if (status_we) begin
            status <= sel.wdata[1:0];
        end
    end

    // pad control, bit 0 latch and bit 1 clock
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            pad_ctrl  <= 2'b00;
            pad_clk_r <= 1'b0;
        end else begin
            if (pad_we) begin
                pad_ctrl <= sel.wdata[1:0];
            end
            pad_clk_r <= pad_clk;
        end
    end

    assign pad_latch = pad_ctrl[0];
    assign pad_clk   = pad_ctrl[1];

    // buttons stand in for left, right and B
    always_ff @(posedge vdp_clk) begin
        if (pad_latch) begin
            pad_state <= {8'b0, btn1, btn3, 5'b0, btn2};
        end

        // shift on the pad clock rising edge
        if (pad_clk && !pad_clk_r) begin
            pad_state <= {1'b0, pad_state[15:1]};
        end
    end

    assign pad_bit = pad_state[0];

endmodule

`default_nettype wire

// File: hdl/bus_arbiter.sv
// bus arbiter
// returns the selected region's read value with a one-cycle ready
// pulse, one cycle after the select strobe

`default_nettype none

module bus_arbiter (
    input  logic                vdp_clk,
    input  logic                vdp_reset,
    input  mmio_pkg::mmio_sel_t sel,
    input  logic [31:0]         ram_rdata,
    input  logic [31:0]         dsp_result,
    input  logic [1:0]          status,
    input  logic                pad_bit,
    output logic                mem_ready,
    output logic [31:0]         mem_rdata
);

    mmio_pkg::region_e region_q;

    // ready trails the strobe by one cycle
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            mem_ready <= 1'b0;
            region_q  <= mmio_pkg::region_none;
        end else begin
            mem_ready <= sel.strobe;
            if (sel.strobe) begin
                region_q <= sel.region;
            end
        end
    end

    // read mux, zero outside the ready cycle
    // writes return the region value too and the cpu drops it
    always_comb begin
        mem_rdata = 32'h0;

        if (mem_ready) begin
            case (region_q)
                mmio_pkg::region_ram: begin
                    mem_rdata = ram_rdata;
                end
                mmio_pkg::region_dsp: begin
                    mem_rdata = dsp_result;
                end
                mmio_pkg::region_status: begin
                    mem_rdata = {30'h0, status};
                end
                mmio_pkg::region_pad: begin
                    mem_rdata = {31'h0, pad_bit};
                end
                default: begin
                    mem_rdata = 32'h0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/mmio_top.sv
// mmio peripheral subsystem top
// decoder feeds ram, multiplier and io ports, the arbiter returns
// read data and ready to the cpu

`default_nettype none

`include "mmio_config.svh"

module mmio_top (
    input  logic               vdp_clk,
    input  logic               vdp_reset,

    // cpu bus
    input  logic               mem_valid,
    input  mmio_pkg::bus_req_t mem_req,
    output logic               mem_ready,
    output logic [31:0]        mem_rdata,

    // board io
    input  logic               btn1,
    input  logic               btn2,
    input  logic               btn3,
    output logic               led_r,
    output logic               led_b
);

    mmio_pkg::mmio_sel_t sel;

    logic [31:0] ram_rdata;
    logic [31:0] dsp_result;
    logic [1:0]  status;
    logic        pad_bit;

    address_decoder address_decoder_inst (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .mem_valid (mem_valid),
        .mem_req   (mem_req),
        .sel       (sel)
    );

    cpu_ram #(
        .depth (`MMIO_RAM_WORDS)
    ) cpu_ram_inst (
        .vdp_clk   (vdp_clk),
        .sel       (sel),
        .ram_rdata (ram_rdata)
    );

    dsp_mult dsp_mult_inst (
        .vdp_clk    (vdp_clk),
        .sel        (sel),
        .dsp_result (dsp_result)
    );

    io_ports io_ports_inst (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .sel       (sel),
        .btn1      (btn1),
        .btn2      (btn2),
        .btn3      (btn3),
        .status    (status),
        .pad_bit   (pad_bit),
        .led_r     (led_r),
        .led_b     (led_b)
    );

    bus_arbiter bus_arbiter_inst (
        .vdp_clk    (vdp_clk),
        .vdp_reset  (vdp_reset),
        .sel        (sel),
        .ram_rdata  (ram_rdata),
        .dsp_result (dsp_result),
        .status     (status),
        .pad_bit    (pad_bit),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata)
    );

endmodule

`default_nettype wire

// File: tb/mmio_tb.sv
// mmio subsystem testbench
// stands in for the cpu on the valid/ready bus and checks the ram,
// the multiplier, the status leds, the gamepad port and unmapped accesses

`default_nettype none

`include "mmio_config.svh"

module mmio_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int aw = `MMIO_ADDR_WIDTH;
    // limit is about four times the 900 cycles of traffic
    localparam int max_cycles = 4000;
    localparam logic [1:0] status_reset = `MMIO_STATUS_RESET;

    logic               vdp_clk;
    logic               vdp_reset;
    logic               mem_valid;
    mmio_pkg::bus_req_t mem_req;
    logic               mem_ready;
    logic [31:0]        mem_rdata;
    logic               btn1;
    logic               btn2;
    logic               btn3;
    logic               led_r;
    logic               led_b;

    int data_errors = 0;
    int timing_errors = 0;
    int cycle_count = 0;

    // reference state
    logic [31:0] ram_model [`MMIO_RAM_WORDS];
    int unsigned pool [16];
    logic [1:0]  status_model;
    logic [31:0] last_product;

    mmio_top mmio_top_inst (
        .vdp_clk   (vdp_clk),
        .vdp_reset (vdp_reset),
        .mem_valid (mem_valid),
        .mem_req   (mem_req),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .btn1      (btn1),
        .btn2      (btn2),
        .btn3      (btn3),
        .led_r     (led_r),
        .led_b     (led_b)
    );

    initial begin
        vdp_clk = 1'b0;
        forever #2 vdp_clk = ~vdp_clk;
    end

    always @(posedge vdp_clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout: tests did not finish within %0d cycles", max_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ready two edges after valid is first seen and high for one cycle only
    ready_latency: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $rose(mem_valid) |-> ##2 mem_ready)
    else begin
        timing_errors++;
        $display("mem_ready missing two cycles after mem_valid rose, at %0t", $time);
    end

    ready_not_early: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        $rose(mem_valid) |=> !mem_ready)
    else begin
        timing_errors++;
        $display("mem_ready came one cycle after mem_valid rose, at %0t", $time);
    end

    ready_single: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        mem_ready |=> !mem_ready)
    else begin
        timing_errors++;
        $display("mem_ready stayed high for more than one cycle, at %0t", $time);
    end

    ready_needs_valid: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        mem_ready |-> mem_valid)
    else begin
        timing_errors++;
        $display("mem_ready seen while mem_valid was low, at %0t", $time);
    end

    // read data is zero outside the ready cycle
    rdata_idle_zero: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        !mem_ready |-> (mem_rdata == 32'h0))
    else begin
        data_errors++;
        $display("Fail mem_rdata: got 0x%08h, expected 0x00000000 outside ready",
                 $sampled(mem_rdata));
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected)
        else begin
            data_errors++;
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, expected);
        end
    endtask

    function automatic logic [aw-1:0] make_addr(input logic [3:0] region,
                                                input int unsigned offset);
        return (aw'(region) << `MMIO_REGION_LSB) | aw'(offset);
    endfunction

    // random upper word address bits alias onto the same ram word
    function automatic logic [aw-1:0] ram_addr(input int unsigned idx);
        int unsigned word_index;
        word_index = $urandom_range(1023) * `MMIO_RAM_WORDS + idx;
        return make_addr(mmio_pkg::region_ram, word_index * 4);
    endfunction

    // one picorv32 style transfer with the request held until ready
    task automatic bus_transfer(input logic [aw-1:0] addr, input logic [3:0] wstrb,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge vdp_clk);
        #1;
        mem_req.addr  = addr;
        mem_req.wstrb = wstrb;
        mem_req.wdata = wdata;
        mem_valid     = 1'b1;
        @(negedge vdp_clk);
        while (!mem_ready) begin
            @(negedge vdp_clk);
        end
        rdata = mem_rdata;
        @(posedge vdp_clk);
        #1;
        mem_valid = 1'b0;
    endtask

    task automatic bus_write(input logic [aw-1:0] addr, input logic [3:0] wstrb,
                             input logic [31:0] wdata);
        logic [31:0] ignored;
        bus_transfer(addr, wstrb, wdata, ignored);
    endtask

    task automatic bus_read(input logic [aw-1:0] addr, output logic [31:0] rdata);
        bus_transfer(addr, 4'h0, 32'h0, rdata);
    endtask

    task automatic check_leds();
        @(negedge vdp_clk);
        check_value("led_r", 32'(led_r), 32'(status_model[0]));
        check_value("led_b", 32'(led_b), 32'(status_model[1]));
    endtask

    task automatic ram_checks();
        int unsigned idx;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic [31:0] rdata;
        // full words first so that every pool word is defined
        for (int i = 0; i < 16; i++) begin
            pool[i] = $urandom_range(`MMIO_RAM_WORDS - 1);
            wdata = $urandom;
            ram_model[pool[i]] = wdata;
            bus_write(ram_addr(pool[i]), 4'hf, wdata);
        end
        for (int i = 0; i < 40; i++) begin
            idx = pool[$urandom_range(15)];
            wstrb = 4'($urandom);
            wdata = $urandom;
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    ram_model[idx][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            bus_write(ram_addr(idx), wstrb, wdata);
        end
        for (int i = 0; i < 32; i++) begin
            idx = pool[i % 16];
            bus_read(ram_addr(idx), rdata);
            check_value("mem_rdata", rdata, ram_model[idx]);
        end
    endtask

    task automatic multiplier_checks();
        logic signed [15:0] a;
        logic signed [15:0] b;
        logic [31:0]        rdata;
        for (int i = 0; i < 10; i++) begin
            // most negative operands first
            a = (i == 0) ? 16'sh8000 : 16'($urandom);
            b = (i < 2) ? 16'sh8000 : 16'($urandom);
            bus_write(make_addr(mmio_pkg::region_dsp, 0), 4'hf, {16'($urandom), a});
            bus_write(make_addr(mmio_pkg::region_dsp, 4), 4'hf, {16'($urandom), b});
            last_product = 32'(int'(a) * int'(b));
            bus_read(make_addr(mmio_pkg::region_dsp, 0), rdata);
            check_value("mem_rdata", rdata, last_product);
        end
    endtask

    task automatic status_checks();
        logic [31:0] rdata;
        for (int v = 0; v < 4; v++) begin
            status_model = 2'(v);
            bus_write(make_addr(mmio_pkg::region_status, 0), 4'hf,
                      {30'($urandom), status_model});
            check_leds();
            bus_read(make_addr(mmio_pkg::region_status, 0), rdata);
            check_value("mem_rdata", rdata, {30'h0, status_model});
        end
    endtask

    task automatic gamepad_checks(input logic [2:0] buttons);
        logic [7:0]  expected_bits;
        logic [31:0] rdata;
        {btn3, btn2, btn1} = buttons;
        // shift-out order is btn2, five zeros, btn3 and btn1
        expected_bits = {buttons[0], buttons[2], 5'b0, buttons[1]};
        bus_write(make_addr(mmio_pkg::region_pad, 0), 4'hf, 32'h1);
        bus_write(make_addr(mmio_pkg::region_pad, 0), 4'hf, 32'h0);
        // presses after the latch falls must not reach the shift register
        {btn3, btn2, btn1} = ~buttons;
        for (int i = 0; i < 8; i++) begin
            bus_read(make_addr(mmio_pkg::region_pad, 0), rdata);
            check_value("mem_rdata", rdata, {31'h0, expected_bits[i]});
            bus_write(make_addr(mmio_pkg::region_pad, 0), 4'hf, 32'h2);
            bus_write(make_addr(mmio_pkg::region_pad, 0), 4'hf, 32'h0);
        end
    endtask

    task automatic unmapped_checks();
        logic [31:0] rdata;
        bus_read(make_addr(4'h7, 0), rdata);
        check_value("mem_rdata", rdata, 32'h0);
        // offsets that would hit a ram word, the status register and operand a
        bus_write(make_addr(4'h9, pool[0] * 4), 4'hf, ~ram_model[pool[0]]);
        bus_write(make_addr(4'hc, 0), 4'hf, {30'h0, ~status_model});
        bus_write(make_addr(4'he, 0), 4'hf, 32'h0000_1234);
        bus_read(make_addr(mmio_pkg::region_ram, pool[0] * 4), rdata);
        check_value("mem_rdata", rdata, ram_model[pool[0]]);
        bus_read(make_addr(mmio_pkg::region_status, 0), rdata);
        check_value("mem_rdata", rdata, {30'h0, status_model});
        check_leds();
        bus_read(make_addr(mmio_pkg::region_dsp, 0), rdata);
        check_value("mem_rdata", rdata, last_product);
    endtask

    initial begin
        void'($urandom(72649));
        vdp_reset    = 1'b1;
        mem_valid    = 1'b0;
        mem_req      = '0;
        btn1         = 1'b0;
        btn2         = 1'b0;
        btn3         = 1'b0;
        status_model = status_reset;
        repeat (5) @(posedge vdp_clk);
        #1;
        vdp_reset = 1'b0;
        // idle bus for a few cycles with the leds at their reset value
        repeat (4) @(posedge vdp_clk);
        check_leds();
        ram_checks();
        multiplier_checks();
        status_checks();
        // one button at a time so that each lands in its own bit
        gamepad_checks(3'b001);
        gamepad_checks(3'b010);
        gamepad_checks(3'b100);
        unmapped_checks();
        repeat (4) @(posedge vdp_clk);
        $display("errors: %0d data, %0d timing", data_errors, timing_errors);
        if (data_errors + timing_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+hdl
hdl/mmio_pkg.sv
hdl/address_decoder.sv
hdl/cpu_ram.sv
hdl/dsp_mult.sv
hdl/io_ports.sv
hdl/bus_arbiter.sv
hdl/mmio_top.sv
tb/mmio_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mmio testbench with verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module mmio_tb -f all.f -o mmio_sim \
    && ./obj_dir/mmio_sim > sim.log 2>&1 \
    || { echo "build or simulation run error"; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log \
    && { echo "test failed"; exit 1; } \
    || { echo "test passed"; exit 0; }
